// File: cpuPipe_params.svh
//----------------------------------------------------------------------
// widths, memory depth and instruction encodings of the pipeline
// opcode 0 decodes as a nop, so a zeroed instruction word is harmless
// immediates are IMM_W bits and always sign-extended
//----------------------------------------------------------------------
`ifndef CPUPIPE_PARAMS_SVH
`define CPUPIPE_PARAMS_SVH

`define DATA_W     16
`define REG_AW     3
`define IMM_W      5
`define DMEM_WORDS 32   // word addressed, low address bits only
`define OP_W       5
`define FN_W       2

// opcode field [15:11]
`define OP_NOP  5'b00000
`define OP_ALU  5'b00001
`define OP_ADDI 5'b00010
`define OP_LD   5'b00011
`define OP_ST   5'b00100
`define OP_BEQZ 5'b00101
`define OP_HALT 5'b00110

// funct field of R-format [1:0]
`define FN_ADD 2'b00
`define FN_SUB 2'b01
`define FN_AND 2'b10
`define FN_XOR 2'b11

`endif

// File: cpuPipe_pkg.sv
//----------------------------------------------------------------------
// instruction views and pipeline register layouts
// every stage register carries its own valid bit; payload is don't
// care while valid is low
//----------------------------------------------------------------------
`include "cpuPipe_params.svh"

package cpuPipe_pkg;

  typedef struct packed {
    logic [`OP_W-1:0]   opcode;
    logic [`REG_AW-1:0] rs;
    logic [`REG_AW-1:0] rt;
    logic [`REG_AW-1:0] rd;
    logic [`FN_W-1:0]   funct;
  } rFmt_t;

  typedef struct packed {
    logic [`OP_W-1:0]   opcode;
    logic [`REG_AW-1:0] rs;
    logic [`REG_AW-1:0] rd;    // same bits as rFmt.rt, store data of ST
    logic [`IMM_W-1:0]  imm;
  } iFmt_t;

  // one word, two decodings
  typedef union packed {
    rFmt_t rFmt;
    iFmt_t iFmt;
  } instr_u;

  typedef struct packed {
    logic             regWrite;
    logic             memRead;
    logic             memWrite;
    logic             isBranch;
    logic             isHalt;
    logic             readsRt;
    logic             aluSrcImm;  // operand b from imm
    logic [`FN_W-1:0] aluOp;
  } ctrl_t;

  typedef struct packed {
    logic               valid;
    logic [`DATA_W-1:0] pc;
    instr_u             instr;
  } ifId_t;

  typedef struct packed {
    logic               valid;
    ctrl_t              ctrl;
    logic [`DATA_W-1:0] pc;
    logic [`REG_AW-1:0] rs;
    logic [`REG_AW-1:0] rt;
    logic [`REG_AW-1:0] rd;
    logic [`DATA_W-1:0] rsVal;
    logic [`DATA_W-1:0] rtVal;
    logic [`DATA_W-1:0] imm;    // already sign-extended
  } idEx_t;

  typedef struct packed {
    logic               valid;
    ctrl_t              ctrl;
    logic [`REG_AW-1:0] rd;
    logic [`DATA_W-1:0] aluResult;
    logic [`DATA_W-1:0] storeData;
  } exMem_t;

  // MEM/WB register, also the register file write and retire port
  typedef struct packed {
    logic               valid;   // register write only
    logic               halt;
    logic [`REG_AW-1:0] rd;
    logic [`DATA_W-1:0] data;
  } wb_t;

endpackage

// File: fetchStage.sv
//----------------------------------------------------------------------
// program counter and IF/ID register
// instruction memory is external and answers in the same cycle
// redirect beats stall; fetch stops for good once HALT is in IF/ID
//----------------------------------------------------------------------
`timescale 1ns/100ps
`include "cpuPipe_params.svh"

module fetchStage
  import cpuPipe_pkg::*;
(
  input  logic               clk,
  input  logic               arstN,
  input  logic               stall,
  input  logic               redirect,
  input  logic [`DATA_W-1:0] redirectPc,
  input  logic [`DATA_W-1:0] instrData,
  output logic [`DATA_W-1:0] instrAddr,
  output ifId_t              ifId
);

  logic [`DATA_W-1:0] pc;
  logic               fetchOff;
  logic               haltInIfId;

  assign instrAddr  = pc;
  assign haltInIfId = ifId.valid && (ifId.instr.rFmt.opcode == `OP_HALT);

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      pc       <= '0;
      fetchOff <= 1'b0;
      ifId     <= '0;
    end else if (redirect) begin
      pc         <= redirectPc;   // younger fetches are dropped
      fetchOff   <= 1'b0;
      ifId.valid <= 1'b0;
    end else if (!stall) begin
      if (fetchOff || haltInIfId) begin
        fetchOff   <= 1'b1;       // pc parks here
        ifId.valid <= 1'b0;
      end else begin
        pc         <= pc + `DATA_W'd2;
        ifId.valid <= 1'b1;
        ifId.pc    <= pc;
        ifId.instr <= instrData;
      end
    end
  end

endmodule

// File: decodeStage.sv
//----------------------------------------------------------------------
// control decode, register file and the ID/EX register
// register file writes from MEM/WB and bypasses a same-cycle write
// load-use stall holds IF/ID one cycle and sends a bubble down
//----------------------------------------------------------------------
`timescale 1ns/100ps
`include "cpuPipe_params.svh"

module decodeStage
  import cpuPipe_pkg::*;
(
  input  logic   clk,
  input  logic   arstN,
  input  ifId_t  ifId,
  input  logic   redirect,
  input  exMem_t exMem,
  input  wb_t    wb,
  output logic   stall,
  output idEx_t  idEx
);

  instr_u             ins;
  ctrl_t              ctrl;
  logic [`REG_AW-1:0] rs;
  logic [`REG_AW-1:0] rt;
  logic [`REG_AW-1:0] rd;
  logic [`DATA_W-1:0] rsVal;
  logic [`DATA_W-1:0] rtVal;
  logic [`DATA_W-1:0] imm;
  logic [`DATA_W-1:0] regs [1 << `REG_AW];
  logic               idExLoadHit;

  assign ins = ifId.instr;
  assign rs  = ins.rFmt.rs;
  assign rt  = ins.rFmt.rt;
  assign rd  = (ins.rFmt.opcode == `OP_ALU) ? ins.rFmt.rd : ins.iFmt.rd;
  assign imm = {{(`DATA_W - `IMM_W){ins.iFmt.imm[`IMM_W-1]}}, ins.iFmt.imm};

  always_comb begin
    ctrl       = '0;
    ctrl.aluOp = `FN_ADD;          // address and addi math
    case (ins.rFmt.opcode)
      `OP_ALU: begin
        ctrl.regWrite = 1'b1;
        ctrl.readsRt  = 1'b1;
        ctrl.aluOp    = ins.rFmt.funct;
      end
      `OP_ADDI: begin
        ctrl.regWrite  = 1'b1;
        ctrl.aluSrcImm = 1'b1;
      end
      `OP_LD: begin
        ctrl.regWrite  = 1'b1;
        ctrl.memRead   = 1'b1;
        ctrl.aluSrcImm = 1'b1;
      end
      `OP_ST: begin
        ctrl.memWrite  = 1'b1;
        ctrl.readsRt   = 1'b1;     // store data sits in bits [7:5]
        ctrl.aluSrcImm = 1'b1;
      end
      `OP_BEQZ: ctrl.isBranch = 1'b1;
      `OP_HALT: ctrl.isHalt   = 1'b1;
      default: ;                   // nop
    endcase
  end

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      for (int i = 0; i < (1 << `REG_AW); i++)
        regs[i] <= '0;
    end else if (wb.valid) begin
      regs[wb.rd] <= wb.data;
    end
  end

  // write before read
  assign rsVal = (wb.valid && wb.rd == rs) ? wb.data : regs[rs];
  assign rtVal = (wb.valid && wb.rd == rt) ? wb.data : regs[rt];

  assign idExLoadHit = idEx.valid && idEx.ctrl.memRead &&
                       (idEx.rd == rs || (ctrl.readsRt && idEx.rd == rt));
  assign stall = ifId.valid && idExLoadHit;

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      idEx <= '0;
    end else begin
      idEx.valid <= ifId.valid && !stall && !redirect;  // bubble
      idEx.ctrl  <= ctrl;
      idEx.pc    <= ifId.pc;
      idEx.rs    <= rs;
      idEx.rt    <= rt;
      idEx.rd    <= rd;
      idEx.rsVal <= rsVal;
      idEx.rtVal <= rtVal;
      idEx.imm   <= imm;
    end
  end

endmodule

// File: executeStage.sv
//----------------------------------------------------------------------
// operand forwarding, ALU, branch resolution and the EX/MEM register
// forwarding order is EX/MEM, then MEM/WB, then the ID/EX values
// a load result is taken from MEM/WB only
//----------------------------------------------------------------------
`timescale 1ns/100ps
`include "cpuPipe_params.svh"

module executeStage
  import cpuPipe_pkg::*;
(
  input  logic               clk,
  input  logic               arstN,
  input  idEx_t              idEx,
  input  wb_t                wb,
  output exMem_t             exMem,
  output logic               redirect,
  output logic [`DATA_W-1:0] redirectPc
);

  logic [`DATA_W-1:0] opA;
  logic [`DATA_W-1:0] fwdB;
  logic [`DATA_W-1:0] opB;
  logic [`DATA_W-1:0] aluResult;

  function automatic logic [`DATA_W-1:0] fwdOperand(
    input logic [`REG_AW-1:0] r,
    input logic [`DATA_W-1:0] regVal,
    input exMem_t             em,
    input wb_t                w
  );
    if (em.valid && em.ctrl.regWrite && !em.ctrl.memRead && em.rd == r)
      return em.aluResult;
    if (w.valid && w.rd == r)
      return w.data;
    return regVal;
  endfunction

  assign opA  = fwdOperand(idEx.rs, idEx.rsVal, exMem, wb);
  assign fwdB = fwdOperand(idEx.rt, idEx.rtVal, exMem, wb);  // also store data
  assign opB  = idEx.ctrl.aluSrcImm ? idEx.imm : fwdB;

  always_comb begin
    case (idEx.ctrl.aluOp)
      `FN_ADD: aluResult = opA + opB;
      `FN_SUB: aluResult = opA - opB;
      `FN_AND: aluResult = opA & opB;
      default: aluResult = opA ^ opB;
    endcase
  end

  // beqz tests rs only, target is pc + 2 + 2*imm
  assign redirect   = idEx.valid && idEx.ctrl.isBranch && (opA == '0);
  assign redirectPc = idEx.pc + `DATA_W'd2 + {idEx.imm[`DATA_W-2:0], 1'b0};

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      exMem <= '0;
    end else begin
      exMem.valid     <= idEx.valid;
      exMem.ctrl      <= idEx.ctrl;
      exMem.rd        <= idEx.rd;
      exMem.aluResult <= aluResult;
      exMem.storeData <= fwdB;
    end
  end

endmodule

// File: memoryStage.sv
//----------------------------------------------------------------------
// data memory and the MEM/WB register
// synchronous write, asynchronous read, addressed by the low bits of
// the ALU result; upper address bits are ignored
//----------------------------------------------------------------------
`timescale 1ns/100ps
`include "cpuPipe_params.svh"

module memoryStage
  import cpuPipe_pkg::*;
(
  input  logic   clk,
  input  logic   arstN,
  input  exMem_t exMem,
  output wb_t    wb
);

  localparam int DMEM_AW = $clog2(`DMEM_WORDS);

  logic [`DATA_W-1:0] dmem [`DMEM_WORDS];
  logic [DMEM_AW-1:0] addr;
  logic [`DATA_W-1:0] rdData;

  assign addr   = exMem.aluResult[DMEM_AW-1:0];
  assign rdData = dmem[addr];

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      for (int i = 0; i < `DMEM_WORDS; i++)
        dmem[i] <= '0;
    end else if (exMem.valid && exMem.ctrl.memWrite) begin
      dmem[addr] <= exMem.storeData;
    end
  end

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      wb <= '0;
    end else begin
      wb.valid <= exMem.valid && exMem.ctrl.regWrite;
      wb.halt  <= exMem.valid && exMem.ctrl.isHalt;
      wb.rd    <= exMem.rd;
      wb.data  <= exMem.ctrl.memRead ? rdData : exMem.aluResult;
    end
  end

endmodule

// File: cpuPipe.sv
//----------------------------------------------------------------------
// five-stage 16-bit pipeline, eight registers
// instrData must answer instrAddr combinationally
// retire port shows each register write; halted is sticky until reset
//----------------------------------------------------------------------
`timescale 1ns/100ps
`include "cpuPipe_params.svh"

module cpuPipe
  import cpuPipe_pkg::*;
(
  input  logic               clk,
  input  logic               arstN,
  input  logic [`DATA_W-1:0] instrData,
  output logic [`DATA_W-1:0] instrAddr,
  output logic               wbValid,
  output logic [`REG_AW-1:0] wbReg,
  output logic [`DATA_W-1:0] wbData,
  output logic               halted
);

  ifId_t              ifId;
  idEx_t              idEx;
  exMem_t             exMem;
  wb_t                wb;
  logic               stall;
  logic               redirect;
  logic [`DATA_W-1:0] redirectPc;
  logic               haltSeen;

  fetchStage u_fetch (.clk, .arstN, .stall, .redirect, .redirectPc,
                      .instrData, .instrAddr, .ifId);

  decodeStage u_decode (.clk, .arstN, .ifId, .redirect, .exMem, .wb,
                        .stall, .idEx);

  executeStage u_execute (.clk, .arstN, .idEx, .wb, .exMem, .redirect, .redirectPc);

  memoryStage u_memory (.clk, .arstN, .exMem, .wb);

  assign wbValid = wb.valid;
  assign wbReg   = wb.rd;
  assign wbData  = wb.data;

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) haltSeen <= 1'b0;
    else if (wb.halt) haltSeen <= 1'b1;
  end

  assign halted = haltSeen || wb.halt;  // high in the retire cycle of HALT

endmodule

// File: cpuPipe_props.sv
//----------------------------------------------------------------------
// fetch address, retire and halt checks on the cpuPipe top level
// branch targets are rebuilt from the fetched branch word, so the
// program must sit below byte address 64
//----------------------------------------------------------------------
`timescale 1ns/100ps
`include "cpuPipe_params.svh"

module cpuPipe_props (
  input logic               clk,
  input logic               arstN,
  input logic [`DATA_W-1:0] instrAddr,
  input logic [`DATA_W-1:0] instrData,
  input logic               wbValid,
  input logic               halted,
  input logic               redirect,
  input logic [`DATA_W-1:0] branchPc
);

  int                 propErrors = 0;
  logic [`DATA_W-1:0] fetched [32];   // word seen at each fetch address
  logic [`DATA_W-1:0] brWord;
  logic [`DATA_W-1:0] brTarget;

  always_ff @(posedge clk)
    fetched[instrAddr[5:1]] <= instrData;

  // pc + 2 + 2*imm, imm sign-extended from the low bits
  assign brWord   = fetched[branchPc[5:1]];
  assign brTarget = branchPc + `DATA_W'd2 +
                    {{(`DATA_W - `IMM_W - 1){brWord[`IMM_W-1]}}, brWord[`IMM_W-1:0], 1'b0};

  resetQuiet: assert property (@(posedge clk)
    !arstN |-> (!wbValid && !halted && instrAddr == '0))
    else begin
      propErrors++;
      $error("outputs not idle during reset");
    end

  // pc moves by +2, holds, or lands on the branch target
  addrStep: assert property (@(posedge clk) disable iff (!arstN)
    $past(redirect) ? (instrAddr == $past(brTarget)) :
    (instrAddr == $past(instrAddr) || instrAddr == $past(instrAddr) + `DATA_W'd2))
    else begin
      propErrors++;
      $error("fetch address step is illegal");
    end

  redirectPulse: assert property (@(posedge clk) disable iff (!arstN)
    redirect |=> !redirect)
    else begin
      propErrors++;
      $error("redirect held longer than one cycle");
    end

  quietAfterHalt: assert property (@(posedge clk) disable iff (!arstN)
    halted |=> !wbValid)
    else begin
      propErrors++;
      $error("register write retired after halt");
    end

endmodule

bind cpuPipe cpuPipe_props u_props (
  .clk(clk), .arstN(arstN), .instrAddr(instrAddr), .instrData(instrData),
  .wbValid(wbValid), .halted(halted), .redirect(redirect), .branchPc(idEx.pc)
);

// File: tb_cpuPipe.sv
//----------------------------------------------------------------------
// program ROM, in-order reference model and retire checks for cpuPipe
// ROM answers instrAddr combinationally, nop outside the program
//----------------------------------------------------------------------
`timescale 1ns/100ps
`include "cpuPipe_params.svh"

module tb_cpuPipe;

  logic        clk = 1'b0;
  logic        arstN;
  logic [15:0] instrData;
  logic [15:0] instrAddr;
  logic        wbValid;
  logic [2:0]  wbReg;
  logic [15:0] wbData;
  logic        halted;
  logic [15:0] rom [32];
  logic [18:0] expQ [$];   // {reg, data} in program order
  string       nameQ [$];
  int          errors = 0;

  cpuPipe u_dut (.clk, .arstN, .instrData, .instrAddr, .wbValid, .wbReg, .wbData, .halted);

  always #5 clk = ~clk;

  assign instrData = (instrAddr < 16'd64) ? rom[instrAddr[5:1]] : 16'h0000;

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    return y ^ (y << 5);
  endfunction

  function automatic logic [15:0] aluWord(input logic [1:0] fn, input logic [2:0] rd,
                                          input logic [2:0] rs, input logic [2:0] rt);
    return {`OP_ALU, rs, rt, rd, fn};
  endfunction

  function automatic logic [15:0] immWord(input logic [4:0] op, input logic [2:0] rd,
                                          input logic [2:0] rs, input logic [4:0] imm);
    return {op, rs, rd, imm};
  endfunction

  task automatic loadProgram();
    logic [31:0] seed;
    seed = 32'h893b;
    for (int i = 0; i < 32; i++)
      rom[i] = 16'h0000;
    for (int i = 0; i < 3; i++) begin  // random addi prologue, r1..r3
      seed   = xorshift(seed);
      rom[i] = immWord(`OP_ADDI, 3'(i + 1), 3'd0, seed[4:0]);
    end
    rom[3]  = aluWord(`FN_ADD, 3'd4, 3'd1, 3'd2);   // mem/wb and ex/mem paths
    rom[4]  = aluWord(`FN_SUB, 3'd5, 3'd4, 3'd3);
    rom[5]  = aluWord(`FN_XOR, 3'd6, 3'd5, 3'd4);
    rom[6]  = aluWord(`FN_AND, 3'd7, 3'd6, 3'd1);
    rom[7]  = immWord(`OP_ADDI, 3'd4, 3'd4, 5'd3);
    rom[8]  = immWord(`OP_ST, 3'd5, 3'd0, 5'd6);
    rom[9]  = immWord(`OP_LD, 3'd6, 3'd0, 5'd6);
    rom[10] = aluWord(`FN_ADD, 3'd1, 3'd6, 3'd6);   // load-use on rs and rt
    rom[11] = immWord(`OP_LD, 3'd2, 3'd0, 5'd6);
    rom[12] = immWord(`OP_ST, 3'd2, 3'd0, 5'd7);    // store data from a load
    rom[13] = immWord(`OP_LD, 3'd3, 3'd0, 5'd7);
    rom[14] = immWord(`OP_ADDI, 3'd7, 3'd0, 5'd5);
    rom[15] = immWord(`OP_BEQZ, 3'd0, 3'd7, 5'd3);  // not taken
    rom[16] = aluWord(`FN_XOR, 3'd5, 3'd7, 3'd7);
    rom[17] = immWord(`OP_BEQZ, 3'd0, 3'd5, 5'd2);  // taken, to word 20
    rom[18] = immWord(`OP_ADDI, 3'd1, 3'd1, 5'd1);  // shadow
    rom[19] = immWord(`OP_ADDI, 3'd2, 3'd2, 5'd1);  // shadow
    rom[20] = immWord(`OP_ADDI, 3'd6, 3'd3, 5'h1e);
    rom[21] = aluWord(`FN_ADD, 3'd3, 3'd6, 3'd4);
    rom[22] = {`OP_HALT, 11'd0};
    rom[23] = immWord(`OP_ADDI, 3'd1, 3'd0, 5'd9);  // past halt
  endtask

  // in-order interpreter, one entry per register write
  task automatic buildExpected();
    logic [15:0] regs [8];
    logic [15:0] mem [32];
    logic [15:0] pc;
    logic [15:0] w;
    logic [15:0] simm;
    logic [15:0] ea;
    logic [15:0] val;
    logic        done;
    string       name;
    for (int i = 0; i < 8; i++)
      regs[i] = '0;
    for (int i = 0; i < 32; i++)
      mem[i] = '0;
    pc   = '0;
    done = 1'b0;
    for (int step = 0; step < 200 && !done; step++) begin
      w    = (pc < 16'd64) ? rom[pc[5:1]] : 16'h0000;
      simm = {{11{w[4]}}, w[4:0]};
      ea   = regs[w[10:8]] + simm;
      name = (pc < 16'd16) ? "aluForward" :
             (pc < 16'd28) ? "loadStore" :
             (pc < 16'd40) ? "branch" : "tail";
      pc   = pc + 16'd2;
      case (w[15:11])
        `OP_ALU: begin
          case (w[1:0])
            `FN_ADD: val = regs[w[10:8]] + regs[w[7:5]];
            `FN_SUB: val = regs[w[10:8]] - regs[w[7:5]];
            `FN_AND: val = regs[w[10:8]] & regs[w[7:5]];
            default: val = regs[w[10:8]] ^ regs[w[7:5]];
          endcase
          regs[w[4:2]] = val;
          expQ.push_back({w[4:2], val});
          nameQ.push_back(name);
        end
        `OP_ADDI, `OP_LD: begin
          val = (w[15:11] == `OP_LD) ? mem[ea[4:0]] : ea;
          regs[w[7:5]] = val;
          expQ.push_back({w[7:5], val});
          nameQ.push_back(name);
        end
        `OP_ST: mem[ea[4:0]] = regs[w[7:5]];
        `OP_BEQZ: begin
          if (regs[w[10:8]] == 16'h0000)
            pc = pc + {simm[14:0], 1'b0};
        end
        `OP_HALT: done = 1'b1;
        default: ;
      endcase
    end
  endtask

  always @(negedge clk) begin
    logic [18:0] want;
    string       name;
    if (arstN && wbValid) begin
      extraWrite: assert (expQ.size() > 0) else begin
        errors++;
        $display("register write r%0d = %h retired with nothing left to expect", wbReg, wbData);
      end
      if (expQ.size() > 0) begin
        want = expQ.pop_front();
        name = nameQ.pop_front();
        retireMatch: assert ({wbReg, wbData} == want) else begin
          errors++;
          $display("FAILED %s: expected r%0d=%h, actual r%0d=%h",
                   name, want[18:16], want[15:0], wbReg, wbData);
        end
      end
    end
  end

  initial begin
    int cycles;
    arstN = 1'b0;
    loadProgram();
    buildExpected();
    repeat (5) @(posedge clk);
    arstN <= 1'b1;
    cycles = 0;
    while (!halted && cycles < 300) begin
      @(negedge clk);
      cycles++;
    end
    haltReached: assert (halted) else begin
      errors++;
      $display("timeout: halted did not rise within %0d cycles", cycles);
    end
    cycles = 0;
    while (cycles < 6) begin  // late writes would still show up here
      @(negedge clk);
      cycles++;
    end
    drained: assert (expQ.size() == 0) else begin
      errors++;
      $display("%0d expected register writes never retired", expQ.size());
    end
    $display("errors: %0d retire checks, %0d property checks", errors, u_dut.u_props.propErrors);
    if (errors == 0 && u_dut.u_props.propErrors == 0)
      $display("=== PASS ===");
    else
      $display("=== FAIL ===");
    $finish;
  end

endmodule

// File: cpuPipe.f
+incdir+.
cpuPipe_pkg.sv
fetchStage.sv
decodeStage.sv
executeStage.sv
memoryStage.sv
cpuPipe.sv
cpuPipe_props.sv
tb_cpuPipe.sv

// File: run.sh
#!/bin/sh
# build and run the cpuPipe testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 --top-module tb_cpuPipe -f cpuPipe.f -o simv
./obj_dir/simv +verilator+error+limit+1000 > sim.log 2>&1 || true
cat sim.log

if grep -q "=== FAIL ===" sim.log; then
  echo "simulation failed"
  exit 1
fi
if ! grep -q "=== PASS ===" sim.log; then
  echo "simulation ended without a result"
  exit 1
fi
